// ==== dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Core and bus widths
`define DC_ADDR_WIDTH 64
`define DC_DATA_WIDTH 64

// Cache organisation
`define DC_LINE_WORDS 8
`define DC_SETS 4
`define DC_WAYS 2

// Address split, low bits first
`define DC_OFFSET_BITS 3
`define DC_WORD_BITS $clog2(`DC_LINE_WORDS)
`define DC_SET_BITS $clog2(`DC_SETS)
`define DC_TAG_BITS (`DC_ADDR_WIDTH - `DC_SET_BITS - `DC_WORD_BITS - `DC_OFFSET_BITS)

// Core access size codes
`define DC_SIZE_B 3'd1
`define DC_SIZE_H 3'd2
`define DC_SIZE_W 3'd4
`define DC_SIZE_D 3'd7

// ACE snoop code that drops a line
`define DC_SNOOP_MAKE_INVALID 4'b1101

`endif

// ==== dcache_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_BITS-1:0]    tag;
        logic [`DC_SET_BITS-1:0]    set;
        logic [`DC_WORD_BITS-1:0]   word;   // Double word within the line
        logic [`DC_OFFSET_BITS-1:0] offset; // Byte within the double word
    } dc_addr_fields_t;

    // Same address word, seen flat or split into cache fields
    typedef union packed {
        logic [`DC_ADDR_WIDTH-1:0] raw;
        dc_addr_fields_t           f;
    } dc_addr_u;

    typedef enum logic [2:0] {
        SIZE_B = `DC_SIZE_B,
        SIZE_H = `DC_SIZE_H,
        SIZE_W = `DC_SIZE_W,
        SIZE_D = `DC_SIZE_D
    } dc_size_e;

    typedef struct packed {
        logic                      read;
        logic                      write;
        dc_addr_u                  address;
        dc_size_e                  size;
        logic [`DC_DATA_WIDTH-1:0] wdata;
    } dc_req_t;

    typedef struct packed {
        logic [`DC_DATA_WIDTH-1:0] rdata;
    } dc_resp_t;

    typedef logic [`DC_LINE_WORDS-1:0][`DC_DATA_WIDTH-1:0] dc_line_t;

    typedef logic [$clog2(`DC_WAYS)-1:0] dc_way_t;

    // Low byte lanes touched by an access, unknown codes select none
    function automatic logic [`DC_DATA_WIDTH-1:0] dc_size_mask(dc_size_e size);
        case (size)
            SIZE_B:  return 64'h0000_0000_0000_00ff;
            SIZE_H:  return 64'h0000_0000_0000_ffff;
            SIZE_W:  return 64'h0000_0000_ffff_ffff;
            SIZE_D:  return '1;
            default: return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== axi_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package axi_pkg;

    // One full line per burst
    localparam logic [7:0] AXI_LEN_LINE   = 8'd7;
    localparam logic [2:0] AXI_SIZE_DW    = 3'd3;   // 8 bytes per beat
    localparam logic [1:0] AXI_BURST_INCR = 2'd1;

    typedef struct packed {
        logic [`DC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_ar_t;

    typedef struct packed {
        logic [`DC_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_aw_t;

    typedef struct packed {
        logic [`DC_DATA_WIDTH-1:0] data;
        logic                      last;
    } axi_r_t;

    typedef struct packed {
        logic [`DC_DATA_WIDTH-1:0]   data;
        logic [`DC_DATA_WIDTH/8-1:0] strb;
        logic                        last;
    } axi_w_t;

    // Snoop address channel
    typedef struct packed {
        logic [`DC_ADDR_WIDTH-1:0] addr;
        logic [3:0]                snoop;
    } axi_ac_t;

endpackage

`default_nettype wire

// ==== dcache_tag_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_tag_store
    import dcache_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  dc_addr_u                lookup_addr,
    output logic                    hit,
    output dc_way_t                 hit_way,
    output dc_way_t                 victim_way,
    output logic                    victim_dirty,
    output logic [`DC_TAG_BITS-1:0] victim_tag,
    input  logic                    fill,
    input  dc_addr_u                fill_addr,
    input  logic                    mark_dirty,
    input  dc_way_t                 mark_way,
    input  logic                    snoop_inval,
    input  dc_addr_u                snoop_addr
);

    logic [`DC_TAG_BITS-1:0] tag_q [`DC_SETS][`DC_WAYS];
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
    logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;
    logic [`DC_WAYS-1:0] match;     // Valid ways whose tag equals the lookup tag
    dc_way_t rr_q;      // Round-robin pick once a set is full

    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid_q[lookup_addr.f.set][w] &&
                       tag_q[lookup_addr.f.set][w] == lookup_addr.f.tag;
            if (match[w]) begin
                hit = 1'b1;
                hit_way = dc_way_t'(w);
            end
        end
    end

    // Lowest invalid way wins, counting down leaves the lowest
    always_comb begin
        victim_way = rr_q;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[lookup_addr.f.set][w])
                victim_way = dc_way_t'(w);
        end
    end

    assign victim_dirty = valid_q[lookup_addr.f.set][victim_way] &&
                          dirty_q[lookup_addr.f.set][victim_way];
    assign victim_tag = tag_q[lookup_addr.f.set][victim_way];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            rr_q <= '0;
        end else begin
            if (fill) begin
                valid_q[fill_addr.f.set][victim_way] <= 1'b1;
                dirty_q[fill_addr.f.set][victim_way] <= 1'b0;
                if (&valid_q[fill_addr.f.set])
                    rr_q <= rr_q + 1'b1;
            end
            if (mark_dirty)
                dirty_q[lookup_addr.f.set][mark_way] <= 1'b1;
            if (snoop_inval) begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                    if (tag_q[snoop_addr.f.set][w] == snoop_addr.f.tag) begin
                        valid_q[snoop_addr.f.set][w] <= 1'b0;   // Dirty data is dropped
                        dirty_q[snoop_addr.f.set][w] <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill)
            tag_q[fill_addr.f.set][victim_way] <= fill_addr.f.tag;
    end

    // A tag is resident in at most one valid way, so hit_way names a single valid line
    a_hit_unique: assert property (@(posedge clock) disable iff (reset) $onehot0(match));

endmodule

`default_nettype wire

// ==== dcache_data_store.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_data_store
    import dcache_pkg::*;
(
    input  logic                      clock,
    input  logic [`DC_SET_BITS-1:0]   rd_set,
    input  dc_way_t                   rd_way,
    input  logic [`DC_WORD_BITS-1:0]  rd_word,
    output logic [`DC_DATA_WIDTH-1:0] rd_data,
    input  logic                      wr_en,
    input  dc_size_e                  wr_size,
    input  logic [`DC_DATA_WIDTH-1:0] wr_data,
    input  logic                      beat_we,
    input  logic [`DC_SET_BITS-1:0]   beat_set,
    input  dc_way_t                   beat_way,
    input  logic [`DC_WORD_BITS-1:0]  beat_idx,
    input  logic [`DC_DATA_WIDTH-1:0] beat_wdata,
    input  logic [`DC_WORD_BITS-1:0]  ev_beat_idx,
    output logic [`DC_DATA_WIDTH-1:0] ev_data
);

    dc_line_t lines_q [`DC_SETS][`DC_WAYS];
    logic [`DC_DATA_WIDTH-1:0] wr_mask;

    assign wr_mask = dc_size_mask(wr_size);

    assign rd_data = lines_q[rd_set][rd_way][rd_word];
    assign ev_data = lines_q[beat_set][beat_way][ev_beat_idx];  // Victim beat for write-back

    always_ff @(posedge clock) begin
        if (beat_we)
            lines_q[beat_set][beat_way][beat_idx] <= beat_wdata;
        // Core store merges only the low bytes
        if (wr_en)
            lines_q[rd_set][rd_way][rd_word] <= (rd_data & ~wr_mask) | (wr_data & wr_mask);
    end

endmodule

`default_nettype wire

// ==== dcache_axi_master.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_axi_master
    import dcache_pkg::*;
    import axi_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start_fill,
    input  dc_addr_u                  fill_addr,
    input  logic                      start_evict,
    input  dc_addr_u                  evict_addr,
    output logic                      fill_done,
    output logic                      evict_done,
    output logic                      beat_we,
    output logic [`DC_WORD_BITS-1:0]  beat_idx,
    output logic [`DC_DATA_WIDTH-1:0] beat_wdata,
    output logic [`DC_WORD_BITS-1:0]  ev_beat_idx,
    input  logic [`DC_DATA_WIDTH-1:0] ev_data,
    output logic                      arvalid,
    input  logic                      arready,
    output axi_ar_t                   ar,
    input  logic                      rvalid,
    output logic                      rready,
    input  axi_r_t                    r,
    output logic                      awvalid,
    input  logic                      awready,
    output axi_aw_t                   aw,
    output logic                      wvalid,
    input  logic                      wready,
    output axi_w_t                    w,
    input  logic                      bvalid,
    output logic                      bready,
    input  logic [1:0]                bresp
);

    localparam logic [`DC_WORD_BITS-1:0] LAST_BEAT = `DC_WORD_BITS'(`DC_LINE_WORDS - 1);

    typedef enum logic [2:0] {M_IDLE, M_AR, M_R, M_AW, M_W, M_B} m_state_e;

    m_state_e state_q;
    logic [`DC_WORD_BITS-1:0] beat_q;
    dc_addr_u addr_q;           // Line address of the burst in flight
    logic fill_done_q;
    logic evict_done_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= M_IDLE;
            beat_q <= '0;
            fill_done_q <= 1'b0;
            evict_done_q <= 1'b0;
        end else begin
            fill_done_q <= 1'b0;
            evict_done_q <= 1'b0;
            case (state_q)
                M_IDLE: begin
                    beat_q <= '0;
                    if (start_fill)
                        state_q <= M_AR;
                    else if (start_evict)
                        state_q <= M_AW;
                end
                M_AR: if (arready) state_q <= M_R;
                M_R: begin
                    if (rvalid) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT) begin
                            state_q <= M_IDLE;
                            fill_done_q <= 1'b1;
                        end
                    end
                end
                M_AW: if (awready) state_q <= M_W;
                M_W: begin
                    if (wready) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT)
                            state_q <= M_B;
                    end
                end
                M_B: begin
                    if (bvalid) begin   // Response code not acted on
                        state_q <= M_IDLE;
                        evict_done_q <= 1'b1;
                    end
                end
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state_q == M_IDLE)
            addr_q <= start_fill ? fill_addr : evict_addr;
    end

    assign fill_done = fill_done_q;
    assign evict_done = evict_done_q;

    assign arvalid = state_q == M_AR;
    assign rready = state_q == M_R;
    assign awvalid = state_q == M_AW;
    assign wvalid = state_q == M_W;
    assign bready = state_q == M_B;

    assign ar = '{addr: addr_q.raw, len: AXI_LEN_LINE, size: AXI_SIZE_DW, burst: AXI_BURST_INCR};
    assign aw = '{addr: addr_q.raw, len: AXI_LEN_LINE, size: AXI_SIZE_DW, burst: AXI_BURST_INCR};
    assign w = '{data: ev_data, strb: '1, last: beat_q == LAST_BEAT};

    // Refill beats go straight into the line array
    assign beat_we = rready && rvalid;
    assign beat_idx = beat_q;
    assign beat_wdata = r.data;
    assign ev_beat_idx = beat_q;

    // Slave and master must agree on the burst length
    a_rlast_beat: assert property (@(posedge clock) disable iff (reset)
        rvalid && rready |-> r.last == (beat_q == LAST_BEAT));

    a_bresp_known: assert property (@(posedge clock) disable iff (reset)
        bvalid && bready |-> !$isunknown(bresp));

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_ctrl
    import dcache_pkg::*;
    import axi_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      req_valid,
    input  dc_req_t                   req,
    output logic                      done,
    output dc_resp_t                  resp,
    output dc_addr_u                  lookup_addr,
    input  logic                      hit,
    input  dc_way_t                   hit_way,
    input  dc_way_t                   victim_way,
    input  logic                      victim_dirty,
    input  logic [`DC_TAG_BITS-1:0]   victim_tag,
    output logic                      fill,
    output logic                      mark_dirty,
    output dc_way_t                   mark_way,
    output logic [`DC_SET_BITS-1:0]   rd_set,
    output dc_way_t                   rd_way,
    output logic [`DC_WORD_BITS-1:0]  rd_word,
    input  logic [`DC_DATA_WIDTH-1:0] rd_data,
    output logic                      wr_en,
    output dc_size_e                  wr_size,
    output logic [`DC_DATA_WIDTH-1:0] wr_data,
    output logic                      start_fill,
    output logic                      start_evict,
    output dc_addr_u                  fill_addr,
    output dc_addr_u                  evict_addr,
    input  logic                      fill_done,
    input  logic                      evict_done,
    input  logic                      acvalid,
    output logic                      acready,
    input  axi_ac_t                   ac,
    output logic                      snoop_inval,
    output dc_addr_u                  snoop_addr
);

    typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FILL, COMPLETE, SNOOP} state_e;

    state_e state_q;
    state_e state_d;
    dc_way_t way_q;     // Way of the access, hit way or chosen victim

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_valid)
                    state_d = LOOKUP;   // Core wins over a pending snoop
                else if (acvalid)
                    state_d = SNOOP;
            end
            LOOKUP: begin
                if (hit)
                    state_d = COMPLETE;
                else if (victim_dirty)
                    state_d = EVICT;
                else
                    state_d = FILL;
            end
            EVICT: if (evict_done) state_d = FILL;
            FILL: if (fill_done) state_d = COMPLETE;
            COMPLETE: state_d = IDLE;
            SNOOP: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state_q <= IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clock) begin
        if (state_q == LOOKUP)
            way_q <= hit ? hit_way : victim_way;
    end

    // Request is held stable by the core until done
    assign lookup_addr = req.address;

    always_comb begin
        fill_addr = req.address;
        fill_addr.f.word = '0;
        fill_addr.f.offset = '0;
        evict_addr = fill_addr;
        evict_addr.f.tag = victim_tag;
    end

    assign start_evict = state_q == LOOKUP && !hit && victim_dirty;
    assign start_fill = (state_q == LOOKUP && !hit && !victim_dirty) ||
                        (state_q == EVICT && evict_done);
    assign fill = state_q == FILL && fill_done;

    assign rd_set = req.address.f.set;
    assign rd_word = req.address.f.word;
    assign rd_way = way_q;

    assign wr_en = state_q == COMPLETE && req.write;
    assign wr_size = req.size;
    assign wr_data = req.wdata;
    assign mark_dirty = wr_en;
    assign mark_way = way_q;

    assign done = state_q == COMPLETE;
    assign resp = '{rdata: rd_data & dc_size_mask(req.size)};

    // Snoop payload is held by the interconnect until acready
    assign acready = state_q == SNOOP;
    assign snoop_inval = state_q == SNOOP && ac.snoop == `DC_SNOOP_MAKE_INVALID;
    assign snoop_addr = dc_addr_u'(ac.addr);

    // Completion answers a live request of one kind, held unchanged through the access
    a_done_req: assert property (@(posedge clock) disable iff (reset)
        done |-> req_valid && (req.read ^ req.write) && $stable(req));

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_top
    import dcache_pkg::*;
    import axi_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     req_valid,
    input  dc_req_t  req,
    output logic     done,
    output dc_resp_t resp,
    output logic     arvalid,
    input  logic     arready,
    output axi_ar_t  ar,
    input  logic     rvalid,
    output logic     rready,
    input  axi_r_t   r,
    output logic     awvalid,
    input  logic     awready,
    output axi_aw_t  aw,
    output logic     wvalid,
    input  logic     wready,
    output axi_w_t   w,
    input  logic     bvalid,
    output logic     bready,
    input  logic [1:0] bresp,
    input  logic     acvalid,
    output logic     acready,
    input  axi_ac_t  ac
);

    dc_addr_u lookup_addr;
    dc_addr_u fill_addr;
    dc_addr_u evict_addr;
    dc_addr_u snoop_addr;
    logic hit;
    logic victim_dirty;
    logic fill;
    logic mark_dirty;
    logic snoop_inval;
    dc_way_t hit_way;
    dc_way_t victim_way;
    dc_way_t mark_way;
    dc_way_t rd_way;
    logic [`DC_TAG_BITS-1:0] victim_tag;
    logic [`DC_SET_BITS-1:0] rd_set;
    logic [`DC_WORD_BITS-1:0] rd_word;
    logic [`DC_DATA_WIDTH-1:0] rd_data;
    logic wr_en;
    dc_size_e wr_size;
    logic [`DC_DATA_WIDTH-1:0] wr_data;
    logic start_fill;
    logic start_evict;
    logic fill_done;
    logic evict_done;
    logic beat_we;
    logic [`DC_WORD_BITS-1:0] beat_idx;
    logic [`DC_WORD_BITS-1:0] ev_beat_idx;
    logic [`DC_DATA_WIDTH-1:0] beat_wdata;
    logic [`DC_DATA_WIDTH-1:0] ev_data;

    dcache_ctrl u_ctrl (
        .clock, .reset, .req_valid, .req, .done, .resp,
        .lookup_addr, .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .fill, .mark_dirty, .mark_way,
        .rd_set, .rd_way, .rd_word, .rd_data, .wr_en, .wr_size, .wr_data,
        .start_fill, .start_evict, .fill_addr, .evict_addr, .fill_done, .evict_done,
        .acvalid, .acready, .ac, .snoop_inval, .snoop_addr
    );

    dcache_tag_store u_tag_store (
        .clock, .reset, .lookup_addr, .hit, .hit_way, .victim_way, .victim_dirty,
        .victim_tag, .fill, .fill_addr, .mark_dirty, .mark_way, .snoop_inval, .snoop_addr
    );

    // Refill and victim ports follow the access line
    dcache_data_store u_data_store (
        .clock, .rd_set, .rd_way, .rd_word, .rd_data, .wr_en, .wr_size, .wr_data,
        .beat_we, .beat_set(rd_set), .beat_way(rd_way), .beat_idx, .beat_wdata,
        .ev_beat_idx, .ev_data
    );

    dcache_axi_master u_axi_master (
        .clock, .reset, .start_fill, .fill_addr, .start_evict, .evict_addr,
        .fill_done, .evict_done, .beat_we, .beat_idx, .beat_wdata, .ev_beat_idx, .ev_data,
        .arvalid, .arready, .ar, .rvalid, .rready, .r,
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .bresp
    );

endmodule

`default_nettype wire

// ==== tb_axi_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_axi_memory
    import axi_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       arvalid,
    output logic       arready,
    input  axi_ar_t    ar,
    output logic       rvalid,
    input  logic       rready,
    output axi_r_t     r,
    input  logic       awvalid,
    output logic       awready,
    input  axi_aw_t    aw,
    input  logic       wvalid,
    output logic       wready,
    input  axi_w_t     w,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp
);

    logic [63:0] mem [logic [63:0]];    // Double words keyed by aligned byte address
    logic [31:0] stall_state;
    logic [63:0] rd_addr;
    logic [63:0] wr_addr;
    logic [3:0] rd_beat;
    logic [3:0] wr_beat;
    logic rd_busy;
    logic wr_busy;
    logic r_taken;      // R beat handshake at the last rising edge
    logic b_taken;      // B handshake at the last rising edge
    int writebacks;

    assign bresp = 2'b00;

    // Untouched memory, mixes every address bit
    function automatic logic [63:0] pattern_word(logic [63:0] a);
        return {a[31:0] ^ a[63:32], a[31:0] ^ 32'hc3a5_9e17};
    endfunction

    function automatic logic [63:0] read_word(logic [63:0] a);
        if (mem.exists(a))
            return mem[a];
        return pattern_word(a);
    endfunction

    // About one cycle in four is a stall
    function logic stall();
        stall_state = stall_state * 32'd1664525 + 32'd1013904223;
        return stall_state[28:27] == 2'b00;
    endfunction

    initial begin
        stall_state = 32'h8672f888;
        writebacks = 0;
        arready = 1'b0;
        rvalid = 1'b0;
        r = '0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
    end

    always @(posedge clock) begin
        r_taken <= rvalid && rready;
        b_taken <= bvalid && bready;
    end

    always @(negedge clock) begin
        if (reset) begin
            arready = 1'b0;
            rvalid = 1'b0;
            r = '0;
            awready = 1'b0;
            wready = 1'b0;
            bvalid = 1'b0;
            rd_busy = 1'b0;
            wr_busy = 1'b0;
            rd_beat = '0;
            wr_beat = '0;
        end else begin
            // Read side, rready is held for the whole refill
            if (r_taken)
                rd_beat = rd_beat + 1'b1;
            if (rd_busy && rd_beat == 4'd8)
                rd_busy = 1'b0;
            arready = 1'b0;
            rvalid = 1'b0;
            if (rd_busy) begin
                if (!stall()) begin
                    rvalid = 1'b1;
                    r.data = read_word(rd_addr + 64'({rd_beat, 3'b000}));
                    r.last = rd_beat == 4'd7;
                end
            end else if (arvalid && !stall()) begin
                arready = 1'b1;     // Accepted at the next rising edge
                rd_busy = 1'b1;
                rd_addr = ar.addr;
                rd_beat = '0;
            end

            // Write side
            if (b_taken) begin
                bvalid = 1'b0;
                wr_busy = 1'b0;
            end
            awready = 1'b0;
            wready = 1'b0;
            if (wr_busy && wr_beat == 4'd8) begin
                if (!bvalid && !stall())
                    bvalid = 1'b1;
            end else if (wr_busy) begin
                if (wvalid && !stall()) begin
                    wready = 1'b1;
                    mem[wr_addr + 64'({wr_beat, 3'b000})] = w.data;
                    wr_beat = wr_beat + 1'b1;
                end
            end else if (awvalid && !stall()) begin
                awready = 1'b1;
                wr_busy = 1'b1;
                wr_addr = aw.addr;
                wr_beat = '0;
                writebacks++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_dcache.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defines.svh"

module tb_dcache
    import dcache_pkg::*;
    import axi_pkg::*;
();

    localparam int NUM_RANDOM = 400;
    localparam int TOTAL_REQS = 2 * NUM_RANDOM + 16;   // Random part, sweep and snoop tests
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * 60;

    logic clock;
    logic reset;
    logic req_valid;
    dc_req_t req;
    logic done;
    dc_resp_t resp;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, bvalid, bready, acvalid, acready;
    axi_ar_t ar;
    axi_r_t r;
    axi_aw_t aw;
    axi_w_t w;
    axi_ac_t ac;
    logic [1:0] bresp;

    logic [31:0] rand_state;
    int error_count;
    int check_count;
    int ar_count;
    int cycle_count;
    logic [63:0] last_ar_addr;
    logic [63:0] wb_addr;       // Line of the write-back in flight
    int wb_beat;
    logic [63:0] model [logic [63:0]];      // Expected double words by address
    bit written_lines [logic [63:0]];
    dc_size_e size_list [4] = '{SIZE_B, SIZE_H, SIZE_W, SIZE_D};

    always #5 clock = ~clock;

    dcache_top u_dcache_top (
        .clock, .reset, .req_valid, .req, .done, .resp,
        .arvalid, .arready, .ar, .rvalid, .rready, .r,
        .awvalid, .awready, .aw, .wvalid, .wready, .w,
        .bvalid, .bready, .bresp, .acvalid, .acready, .ac
    );

    tb_axi_memory u_mem (
        .clock, .reset, .arvalid, .arready, .ar, .rvalid, .rready, .r,
        .awvalid, .awready, .aw, .wvalid, .wready, .w, .bvalid, .bready, .bresp
    );

    function logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [63:0] pattern_word(logic [63:0] a);
        return {a[31:0] ^ a[63:32], a[31:0] ^ 32'hc3a5_9e17};
    endfunction

    function automatic logic [63:0] expected_word(logic [63:0] a);
        if (model.exists(a))
            return model[a];
        return pattern_word(a);
    endfunction

    // Low bytes covered by an access size
    function automatic logic [63:0] size_mask(dc_size_e s);
        int nbytes;
        nbytes = (s == SIZE_B) ? 1 : (s == SIZE_H) ? 2 : (s == SIZE_W) ? 4 : 8;
        if (nbytes == 8)
            return '1;
        return (64'd1 << (8 * nbytes)) - 64'd1;
    endfunction

    function automatic dc_addr_u make_addr(logic [`DC_TAG_BITS-1:0] tag, logic [1:0] set,
                                           logic [2:0] word);
        dc_addr_u a;
        a.f.tag = tag;
        a.f.set = set;
        a.f.word = word;
        a.f.offset = '0;
        return a;
    endfunction

    task automatic check_resp(input dc_resp_t got, input dc_resp_t exp, input logic [63:0] a);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t resp.rdata at %h: got %h expected %h", $time, a, got.rdata,
                     exp.rdata);
        end
    endtask

    task automatic check_ar(input axi_ar_t got);
        axi_ar_t exp;
        exp = '{addr: {got.addr[63:6], 6'b0}, len: 8'd7, size: 3'd3, burst: 2'd1};
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t ar: got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_aw(input axi_aw_t got);
        axi_aw_t exp;
        exp = '{addr: {got.addr[63:6], 6'b0}, len: 8'd7, size: 3'd3, burst: 2'd1};
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t aw: got %h expected %h", $time, got, exp);
        end
        if (!written_lines.exists(got.addr)) begin
            error_count++;
            $display("Write-back at %0t to line %h that the core never wrote", $time, got.addr);
        end
    endtask

    // Write-back beat carries the model data of its double word
    task automatic check_w(input axi_w_t got, input logic [63:0] a, input logic is_last);
        axi_w_t exp;
        exp = '{data: expected_word(a), strb: '1, last: is_last};
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t w at %h: got %h expected %h", $time, a, got, exp);
        end
    endtask

    // Starts and ends on a falling edge, request held through the done cycle
    task automatic run_access(input dc_req_t rq, output dc_resp_t rs);
        req = rq;
        req_valid = 1'b1;
        do @(negedge clock); while (!done);
        rs = resp;
        @(negedge clock);
        req_valid = 1'b0;
    endtask

    task automatic read_check(input dc_addr_u a, input dc_size_e s);
        dc_req_t rq;
        dc_resp_t rs;
        dc_resp_t exp;
        rq = '{read: 1'b1, write: 1'b0, address: a, size: s, wdata: '0};
        run_access(rq, rs);
        exp.rdata = expected_word(a.raw) & size_mask(s);
        check_resp(rs, exp, a.raw);
    endtask

    task automatic write_access(input dc_addr_u a, input dc_size_e s, input logic [63:0] d);
        dc_req_t rq;
        dc_resp_t rs;
        logic [63:0] m;
        rq = '{read: 1'b0, write: 1'b1, address: a, size: s, wdata: d};
        m = size_mask(s);
        model[a.raw] = (expected_word(a.raw) & ~m) | (d & m);
        written_lines[{a.raw[63:6], 6'b0}] = 1'b1;
        run_access(rq, rs);
    endtask

    task automatic send_snoop(input logic [63:0] a, input logic [3:0] code);
        acvalid = 1'b1;
        ac = '{addr: a, snoop: code};
        do @(negedge clock); while (!acready);
        @(negedge clock);
        acvalid = 1'b0;
    endtask

    // Handshakes sampled at the edge where they complete
    always @(posedge clock) begin
        if (!reset) begin
            if (arvalid && arready) begin
                check_ar(ar);
                ar_count++;
                last_ar_addr = ar.addr;
            end
            if (awvalid && awready) begin
                check_aw(aw);
                wb_addr = aw.addr;
                wb_beat = 0;
            end
            if (wvalid && wready) begin
                check_w(w, wb_addr + 64'(8 * wb_beat), wb_beat == 7);
                wb_beat++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        dc_addr_u a;
        dc_addr_u ro;
        int tag_i;
        int n;
        clock = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        acvalid = 1'b0;
        ac = '0;
        rand_state = 32'h8672f888;
        error_count = 0;
        check_count = 0;
        ar_count = 0;
        cycle_count = 0;
        last_ar_addr = '0;
        wb_addr = '0;
        wb_beat = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Six tags over four sets force evictions in two ways
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = next_random();
            tag_i = int'(rnd[15:8]) % 6;
            a = make_addr(`DC_TAG_BITS'(32'h100 + tag_i), rnd[17:16], rnd[20:18]);
            if (rnd[31])
                write_access(a, size_list[rnd[22:21]], {next_random(), next_random()});
            else
                read_check(a, size_list[rnd[22:21]]);
        end

        // MakeInvalid on a resident read-only line forces a new refill
        ro = make_addr(`DC_TAG_BITS'(32'h800), 2'd1, 3'd2);
        read_check(ro, SIZE_D);
        read_check(ro, SIZE_D);
        n = ar_count;
        send_snoop(ro.raw, `DC_SNOOP_MAKE_INVALID);
        read_check(ro, SIZE_W);
        if (ar_count != n + 1 || last_ar_addr != {ro.raw[63:6], 6'b0}) begin
            error_count++;
            $display("MakeInvalid snoop at %0t did not force a refill of %h", $time, ro.raw);
        end

        // Any other snoop code leaves the line in place
        ro = make_addr(`DC_TAG_BITS'(32'h801), 2'd2, 3'd5);
        read_check(ro, SIZE_H);
        read_check(ro, SIZE_D);
        n = ar_count;
        send_snoop(ro.raw, 4'b0000);
        read_check(ro, SIZE_B);
        if (ar_count != n) begin
            error_count++;
            $display("Snoop with code 0 at %0t caused a refill of %h", $time, ro.raw);
        end

        // Sweep every written double word back through the cache
        foreach (model[k])
            read_check(make_addr(k[63:8], k[7:6], k[5:3]), SIZE_D);

        $display("Checks %0d, errors %0d, AR bursts %0d, write-backs %0d", check_count,
                 error_count, ar_count, u_mem.writebacks);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
dcache_pkg.sv
axi_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_axi_master.sv
dcache_ctrl.sv
dcache_top.sv
tb_axi_memory.sv
tb_dcache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
